//--- rtl/axi_tlb_pkg.sv
// shared widths, page-table entry layout, response codes and channel structs for the read translator
package axi_tlb_pkg;

	// address split
	localparam int ADDR_W     = 64;
	localparam int PAGE_OFS_W = 12;
	localparam int VPN_W      = 52;

	// axi channel fields
	localparam int ID_W   = 16;
	localparam int LEN_W  = 8;
	localparam int SIZE_W = 3;
	localparam int DATA_W = 512;

	// page table geometry
	localparam int PTE_W         = 64;
	localparam int PTES_PER_LINE = 8;
	localparam int PPN_W         = 24;
	localparam int TAG_W         = 36;
	localparam int PT_INDEX_W    = 21;
	localparam int LINE_OFS_W    = $clog2(DATA_W / 8);

	// table sits above every page reachable through a 24-bit ppn
	localparam logic [ADDR_W-1:0] PT_BASE      = 64'h0000_0010_0000_0000;
	// 64 bytes per beat
	localparam logic [SIZE_W-1:0] PT_LINE_SIZE = 3'b110;

	// entry bit positions
	localparam int PTE_PRESENT_BIT = 0;
	localparam int PTE_READ_BIT    = 1;
	localparam int PTE_PPN_LSB     = 4;
	localparam int PTE_TAG_LSB     = 28;

	// metadata, page and result queues
	localparam int QUEUE_LD = 4;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	// one read request
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
		logic [SIZE_W-1:0] size;
	} ar_req_t;

	// request fields held while the translation is pending
	typedef struct packed {
		logic [ID_W-1:0]       id;
		logic [LEN_W-1:0]      len;
		logic [SIZE_W-1:0]     size;
		logic [PAGE_OFS_W-1:0] ofs;
	} ar_meta_t;

	// translation result, ppn already zero-extended
	typedef struct packed {
		logic [VPN_W-1:0] ppn;
		logic             ok;
	} xlate_t;

	// one read data beat
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [DATA_W-1:0] data;
		axi_resp_e         resp;
		logic              last;
	} r_beat_t;

endpackage

//--- rtl/sync_fifo.sv
// synchronous first-word-fall-through FIFO; the head entry shows on rd_data whenever not empty
`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH     = 8,
	parameter int LOG_DEPTH = 4
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	output logic             full,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty
);

	localparam int DEPTH = 1 << LOG_DEPTH;

	logic [WIDTH-1:0]   mem [DEPTH];
	logic [LOG_DEPTH:0] wr_ptr;
	logic [LOG_DEPTH:0] rd_ptr;
	logic               do_wr;
	logic               do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// extra pointer bit tells full from empty
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[LOG_DEPTH] != rd_ptr[LOG_DEPTH]) &&
	               (wr_ptr[LOG_DEPTH-1:0] == rd_ptr[LOG_DEPTH-1:0]);

	assign rd_data = mem[rd_ptr[LOG_DEPTH-1:0]];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_data;
		end
	end

endmodule

//--- rtl/pte_walker.sv
// page-table walker; fetches one line per virtual page and returns translations in request order
`timescale 1ns/100ps

module pte_walker import axi_tlb_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic [VPN_W-1:0] vpn_req,
	input  logic             vpn_req_valid,
	output logic             vpn_req_ready,
	output ar_req_t          pt_ar,
	output logic             pt_ar_valid,
	input  logic             pt_ar_ready,
	input  r_beat_t          pt_r,
	input  logic             pt_r_valid,
	output logic             pt_r_ready,
	output xlate_t           xlate,
	output logic             xlate_valid,
	input  logic             xlate_ready
);

	logic                                  pvq_full;
	logic                                  pvq_empty;
	logic [VPN_W-1:0]                      pvq_head;
	logic                                  laq_full;
	logic                                  laq_empty;
	logic [ADDR_W-1:0]                     laq_head;
	logic [ADDR_W-1:0]                     line_addr;
	logic [PT_INDEX_W+LINE_OFS_W-1:0]      line_index;
	logic                                  req_fire;
	logic                                  pt_r_fire;
	logic                                  xlate_fire;
	logic                                  rq_empty;
	logic [QUEUE_LD:0]                     held;
	logic                                  line_valid;
	logic [DATA_W-1:0]                     line_data;
	logic [VPN_W-1:0]                      line_vpn;
	logic                                  line_ok;
	logic [PTES_PER_LINE-1:0]              hit;
	logic [PTES_PER_LINE-1:0][PPN_W-1:0]   hit_ppn;
	logic [PPN_W-1:0]                      ppn_merge;
	xlate_t                                result;

	assign vpn_req_ready = !pvq_full && !laq_full;
	assign req_fire      = vpn_req_valid && vpn_req_ready;

	// low vpn bits pick the 64-byte line
	assign line_index = {vpn_req[PT_INDEX_W-1:0], {LINE_OFS_W{1'b0}}};
	assign line_addr  = PT_BASE | {{(ADDR_W-PT_INDEX_W-LINE_OFS_W){1'b0}}, line_index};

	sync_fifo #(.WIDTH(VPN_W), .LOG_DEPTH(QUEUE_LD)) pending_vpn_q (
		.clk(clk), .rst(rst),
		.wr_en(req_fire), .wr_data(vpn_req), .full(pvq_full),
		.rd_en(pt_r_fire), .rd_data(pvq_head), .empty(pvq_empty)
	);

	sync_fifo #(.WIDTH(ADDR_W), .LOG_DEPTH(QUEUE_LD)) line_addr_q (
		.clk(clk), .rst(rst),
		.wr_en(req_fire), .wr_data(line_addr), .full(laq_full),
		.rd_en(pt_ar_valid && pt_ar_ready), .rd_data(laq_head), .empty(laq_empty)
	);

	always_comb begin
		pt_ar.id   = '0;
		pt_ar.addr = laq_head;
		pt_ar.len  = '0;
		pt_ar.size = PT_LINE_SIZE;
	end
	assign pt_ar_valid = !laq_empty;

	// held counts lines taken but not yet handed out, so it tops out at the queue depth
	assign pt_r_ready = !pvq_empty && !held[QUEUE_LD];
	assign pt_r_fire  = pt_r_valid && pt_r_ready;
	assign xlate_fire = xlate_valid && xlate_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			held       <= '0;
			line_valid <= 1'b0;
		end else begin
			line_valid <= pt_r_fire;
			if (pt_r_fire && !xlate_fire) begin
				held <= held + 1'b1;
			end else if (!pt_r_fire && xlate_fire) begin
				held <= held - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pt_r_fire) begin
			line_data <= pt_r.data;
			line_vpn  <= pvq_head;
			line_ok   <= (pt_r.resp == RESP_OKAY);
		end
	end

	// eight entry checks side by side
	for (genvar g = 0; g < PTES_PER_LINE; g++) begin : g_check
		logic [PTE_W-1:0] pte;
		assign pte = line_data[g*PTE_W +: PTE_W];
		assign hit[g] = pte[PTE_PRESENT_BIT] && pte[PTE_READ_BIT] &&
		                (line_vpn == {{(VPN_W-TAG_W){1'b0}}, pte[PTE_TAG_LSB +: TAG_W]});
		assign hit_ppn[g] = hit[g] ? pte[PTE_PPN_LSB +: PPN_W] : '0;
	end

	always_comb begin
		ppn_merge = '0;
		for (int i = 0; i < PTES_PER_LINE; i++) begin
			ppn_merge |= hit_ppn[i];
		end
	end

	// a line fetched with an error never translates
	assign result.ok  = line_ok && (|hit);
	assign result.ppn = {{(VPN_W-PPN_W){1'b0}}, ppn_merge};

	sync_fifo #(.WIDTH($bits(xlate_t)), .LOG_DEPTH(QUEUE_LD)) result_q (
		.clk(clk), .rst(rst),
		.wr_en(line_valid), .wr_data(result), .full(),
		.rd_en(xlate_fire), .rd_data(xlate), .empty(rq_empty)
	);

	assign xlate_valid = !rq_empty;

endmodule

//--- rtl/phys_read_arbiter.sv
// shares the physical read port between page-table fetches and data reads, tagging source in id bit 0
`timescale 1ns/100ps

module phys_read_arbiter import axi_tlb_pkg::*; (
	input  ar_req_t pt_ar,
	input  logic    pt_ar_valid,
	output logic    pt_ar_ready,
	output r_beat_t pt_r,
	output logic    pt_r_valid,
	input  logic    pt_r_ready,
	input  ar_req_t data_ar,
	input  logic    data_ar_valid,
	output logic    data_ar_ready,
	output r_beat_t data_r,
	output logic    data_r_valid,
	input  logic    data_r_ready,
	output ar_req_t phys_ar,
	output logic    phys_ar_valid,
	input  logic    phys_ar_ready,
	input  r_beat_t phys_r,
	input  logic    phys_r_valid,
	output logic    phys_r_ready
);

	logic    r_to_data;
	r_beat_t r_down;

	// page-table fetch has priority
	always_comb begin
		if (pt_ar_valid) begin
			phys_ar    = pt_ar;
			phys_ar.id = {pt_ar.id[ID_W-2:0], 1'b0};
		end else begin
			phys_ar    = data_ar;
			phys_ar.id = {data_ar.id[ID_W-2:0], 1'b1};
		end
	end

	assign phys_ar_valid = pt_ar_valid || data_ar_valid;
	assign pt_ar_ready   = phys_ar_ready;
	assign data_ar_ready = phys_ar_ready && !pt_ar_valid;

	// returning beats steered by the source bit
	assign r_to_data = phys_r.id[0];

	always_comb begin
		r_down    = phys_r;
		r_down.id = {1'b0, phys_r.id[ID_W-1:1]};
	end

	assign pt_r         = r_down;
	assign data_r       = r_down;
	assign pt_r_valid   = phys_r_valid && !r_to_data;
	assign data_r_valid = phys_r_valid && r_to_data;
	assign phys_r_ready = r_to_data ? data_r_ready : pt_r_ready;

endmodule

//--- rtl/tlb_ctrl.sv
// translator control; queues client reads, pairs them with translations, forwards or faults each burst
`timescale 1ns/100ps

module tlb_ctrl import axi_tlb_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  ar_req_t          ar,
	input  logic             ar_valid,
	output logic             ar_ready,
	output r_beat_t          r,
	output logic             r_valid,
	input  logic             r_ready,
	output logic [VPN_W-1:0] vpn_req,
	output logic             vpn_req_valid,
	input  logic             vpn_req_ready,
	input  xlate_t           xlate,
	input  logic             xlate_valid,
	output logic             xlate_ready,
	output ar_req_t          data_ar,
	output logic             data_ar_valid,
	input  logic             data_ar_ready,
	input  r_beat_t          data_r,
	input  logic             data_r_valid,
	output logic             data_r_ready
);

	// one entry per paired burst, in client order
	typedef struct packed {
		logic [ID_W-1:0]  id;
		logic [LEN_W-1:0] len;
		logic             fwd;
	} out_entry_t;

	logic             ar_fire;
	ar_meta_t         meta_in;
	ar_meta_t         meta_head;
	logic             mq_full;
	logic             mq_empty;
	logic             pq_full;
	logic             pq_empty;
	logic             pair_avail;
	logic             pair_go;
	out_entry_t       out_in;
	out_entry_t       out_head;
	logic             oq_full;
	logic             oq_empty;
	logic             r_fire;
	logic [LEN_W-1:0] beat_cnt;

	// both queues take the request together
	assign ar_ready = !mq_full && !pq_full;
	assign ar_fire  = ar_valid && ar_ready;

	assign meta_in.id   = ar.id;
	assign meta_in.len  = ar.len;
	assign meta_in.size = ar.size;
	assign meta_in.ofs  = ar.addr[PAGE_OFS_W-1:0];

	sync_fifo #(.WIDTH($bits(ar_meta_t)), .LOG_DEPTH(QUEUE_LD)) meta_q (
		.clk(clk), .rst(rst),
		.wr_en(ar_fire), .wr_data(meta_in), .full(mq_full),
		.rd_en(pair_go), .rd_data(meta_head), .empty(mq_empty)
	);

	sync_fifo #(.WIDTH(VPN_W), .LOG_DEPTH(1)) page_q (
		.clk(clk), .rst(rst),
		.wr_en(ar_fire), .wr_data(ar.addr[ADDR_W-1:PAGE_OFS_W]), .full(pq_full),
		.rd_en(vpn_req_valid && vpn_req_ready), .rd_data(vpn_req), .empty(pq_empty)
	);

	assign vpn_req_valid = !pq_empty;

	// pair head metadata with head translation
	assign pair_avail    = !mq_empty && xlate_valid && !oq_full;
	assign pair_go       = pair_avail && (!xlate.ok || data_ar_ready);
	assign xlate_ready   = pair_go;
	assign data_ar_valid = pair_avail && xlate.ok;

	assign data_ar.id   = meta_head.id;
	assign data_ar.addr = {xlate.ppn, meta_head.ofs};
	assign data_ar.len  = meta_head.len;
	assign data_ar.size = meta_head.size;

	assign out_in.id  = meta_head.id;
	assign out_in.len = meta_head.len;
	assign out_in.fwd = xlate.ok;

	sync_fifo #(.WIDTH($bits(out_entry_t)), .LOG_DEPTH(QUEUE_LD)) out_q (
		.clk(clk), .rst(rst),
		.wr_en(pair_go), .wr_data(out_in), .full(oq_full),
		.rd_en(r_fire && r.last), .rd_data(out_head), .empty(oq_empty)
	);

	// forwarded bursts pass through, faults are generated here
	always_comb begin
		r.id = out_head.id;
		if (out_head.fwd) begin
			r.data = data_r.data;
			r.resp = data_r.resp;
			r.last = data_r.last;
		end else begin
			r.data = '0;
			r.resp = RESP_SLVERR;
			r.last = (beat_cnt == out_head.len);
		end
	end

	assign r_valid      = !oq_empty && (!out_head.fwd || data_r_valid);
	assign data_r_ready = !oq_empty && out_head.fwd && r_ready;
	assign r_fire       = r_valid && r_ready;

	// beat position within the current burst
	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
		end else if (r_fire) begin
			if (r.last) begin
				beat_cnt <= '0;
			end else begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

endmodule

//--- rtl/axi_tlb_top.sv
// read-only AXI address translator top; virtual reads in, physical reads out
`timescale 1ns/100ps

module axi_tlb_top import axi_tlb_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  ar_req_t ar,
	input  logic    ar_valid,
	output logic    ar_ready,
	output r_beat_t r,
	output logic    r_valid,
	input  logic    r_ready,
	output ar_req_t phys_ar,
	output logic    phys_ar_valid,
	input  logic    phys_ar_ready,
	input  r_beat_t phys_r,
	input  logic    phys_r_valid,
	output logic    phys_r_ready
);

	// translation request and result
	logic [VPN_W-1:0] vpn_req;
	logic             vpn_req_valid;
	logic             vpn_req_ready;
	xlate_t           xlate;
	logic             xlate_valid;
	logic             xlate_ready;

	// page-table side of the arbiter
	ar_req_t pt_ar;
	logic    pt_ar_valid;
	logic    pt_ar_ready;
	r_beat_t pt_r;
	logic    pt_r_valid;
	logic    pt_r_ready;

	// data side of the arbiter
	ar_req_t data_ar;
	logic    data_ar_valid;
	logic    data_ar_ready;
	r_beat_t data_r;
	logic    data_r_valid;
	logic    data_r_ready;

	tlb_ctrl ctrl (
		.clk(clk), .rst(rst),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready),
		.vpn_req(vpn_req), .vpn_req_valid(vpn_req_valid), .vpn_req_ready(vpn_req_ready),
		.xlate(xlate), .xlate_valid(xlate_valid), .xlate_ready(xlate_ready),
		.data_ar(data_ar), .data_ar_valid(data_ar_valid), .data_ar_ready(data_ar_ready),
		.data_r(data_r), .data_r_valid(data_r_valid), .data_r_ready(data_r_ready)
	);

	pte_walker walker (
		.clk(clk), .rst(rst),
		.vpn_req(vpn_req), .vpn_req_valid(vpn_req_valid), .vpn_req_ready(vpn_req_ready),
		.pt_ar(pt_ar), .pt_ar_valid(pt_ar_valid), .pt_ar_ready(pt_ar_ready),
		.pt_r(pt_r), .pt_r_valid(pt_r_valid), .pt_r_ready(pt_r_ready),
		.xlate(xlate), .xlate_valid(xlate_valid), .xlate_ready(xlate_ready)
	);

	phys_read_arbiter arb (
		.pt_ar(pt_ar), .pt_ar_valid(pt_ar_valid), .pt_ar_ready(pt_ar_ready),
		.pt_r(pt_r), .pt_r_valid(pt_r_valid), .pt_r_ready(pt_r_ready),
		.data_ar(data_ar), .data_ar_valid(data_ar_valid), .data_ar_ready(data_ar_ready),
		.data_r(data_r), .data_r_valid(data_r_valid), .data_r_ready(data_r_ready),
		.phys_ar(phys_ar), .phys_ar_valid(phys_ar_valid), .phys_ar_ready(phys_ar_ready),
		.phys_r(phys_r), .phys_r_valid(phys_r_valid), .phys_r_ready(phys_r_ready)
	);

endmodule

//--- bench/phys_mem_model.sv
// physical memory responder for the bench; serves page-table lines and data beats from fixed rules
`timescale 1ns/100ps

module phys_mem_model import axi_tlb_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  ar_req_t phys_ar,
	input  logic    phys_ar_valid,
	output logic    phys_ar_ready,
	output r_beat_t phys_r,
	output logic    phys_r_valid,
	input  logic    phys_r_ready
);

	integer           seed = 32'h3552_832c;
	ar_req_t          pend[$];
	logic [LEN_W-1:0] beat = '0;
	logic             fired = 1'b0;
	logic             ar_ready_q = 1'b0;
	logic             r_valid_q = 1'b0;
	r_beat_t          r_q = '0;

	assign phys_ar_ready = ar_ready_q;
	assign phys_r_valid  = r_valid_q;
	assign phys_r        = r_q;

	// line v keeps its only entry in slot v mod 8
	function automatic logic [DATA_W-1:0] beat_data(input ar_req_t req,
			input logic [LEN_W-1:0] k);
		logic [DATA_W-1:0]     d;
		logic [PT_INDEX_W-1:0] v;
		logic [PTE_W-1:0]      pte;
		d = '0;
		pte = '0;
		v = req.addr[LINE_OFS_W +: PT_INDEX_W];
		if (req.addr >= PT_BASE) begin
			pte[PTE_PRESENT_BIT] = (v[2:0] != 3'd7);
			pte[PTE_READ_BIT] = (v[1:0] != 2'd3);
			pte[PTE_PPN_LSB +: PPN_W] = v ^ 24'h5a5;
			pte[PTE_TAG_LSB +: TAG_W] = {{(TAG_W-PT_INDEX_W){1'b0}}, v};
			d[v[2:0]*PTE_W +: PTE_W] = pte;
		end else begin
			d = {(DATA_W/ADDR_W){req.addr + ADDR_W'(k)}};
		end
		return d;
	endfunction

	// handshakes are taken at the rising edge
	always @(posedge clk) begin
		fired = !rst && r_valid_q && phys_r_ready;
		if (rst) begin
			pend.delete();
			beat = '0;
		end else begin
			if (phys_ar_valid && ar_ready_q) begin
				pend.push_back(phys_ar);
			end
			if (fired) begin
				if (r_q.last) begin
					pend.delete(0);
					beat = '0;
				end else begin
					beat = beat + 1'b1;
				end
			end
		end
	end

	// random gaps on both channels, a beat stays put until taken
	always @(negedge clk) begin
		if (rst) begin
			ar_ready_q = 1'b0;
			r_valid_q  = 1'b0;
		end else begin
			ar_ready_q = (($random(seed) & 7) != 0);
			if (!r_valid_q || fired) begin
				r_valid_q = (pend.size() > 0) && (($random(seed) & 3) != 0);
				if (r_valid_q) begin
					r_q.id   = pend[0].id;
					r_q.data = beat_data(pend[0], beat);
					r_q.resp = RESP_OKAY;
					r_q.last = (beat == pend[0].len);
				end
			end
		end
	end

endmodule

//--- bench/axi_tlb_tb.sv
// simulation top that drives client reads and checks every returned beat against memory rules
`timescale 1ns/100ps

module axi_tlb_tb import axi_tlb_pkg::*; ();

	localparam int RAND_REQS = 40;
	localparam int NUM_REQS  = 3 + 2 * RAND_REQS;

	integer  seed = 32'h3552_832c;
	logic    clk = 1'b0;
	logic    rst = 1'b1;
	ar_req_t ar = '0;
	logic    ar_valid = 1'b0;
	logic    ar_ready;
	r_beat_t r;
	logic    r_valid;
	logic    r_ready = 1'b1;
	logic    stall_en = 1'b0;
	ar_req_t phys_ar;
	logic    phys_ar_valid;
	logic    phys_ar_ready;
	r_beat_t phys_r;
	logic    phys_r_valid;
	logic    phys_r_ready;

	// expected beats in acceptance order
	r_beat_t exp_q[$];
	// sizes of forwarded bursts in acceptance order
	logic [SIZE_W-1:0] size_q[$];
	r_beat_t stall_beat;
	logic    stall_seen = 1'b0;
	int      beats_seen = 0;
	int      beat_errors = 0;
	int      seq_errors = 0;

	always #2 clk = ~clk;

	axi_tlb_top uut (.*);

	phys_mem_model mem (.*);

	// Present and readable decide between forwarding and a local fault.
	function automatic void expect_burst(input ar_req_t req);
		logic [VPN_W-1:0]      vpn;
		logic [PT_INDEX_W-1:0] v;
		logic                  mapped;
		logic [ADDR_W-1:0]     pa;
		r_beat_t               b;
		vpn = req.addr[ADDR_W-1:PAGE_OFS_W];
		v = vpn[PT_INDEX_W-1:0];
		// the line's only entry carries the low index bits as its tag
		mapped = (vpn == VPN_W'(v)) && (v[2:0] != 3'd7) && (v[1:0] != 2'd3);
		pa = {{(ADDR_W-PPN_W-PAGE_OFS_W){1'b0}}, v ^ 24'h5a5, req.addr[PAGE_OFS_W-1:0]};
		if (mapped) begin
			size_q.push_back(req.size);
		end
		for (int k = 0; k <= int'(req.len); k++) begin
			b.id = req.id;
			b.last = (k == int'(req.len));
			b.data = mapped ? {(DATA_W/ADDR_W){pa + ADDR_W'(k)}} : '0;
			b.resp = mapped ? RESP_OKAY : RESP_SLVERR;
			exp_q.push_back(b);
		end
	endfunction

	// accepted reads add expected beats and client beats remove them
	always @(posedge clk) begin
		r_beat_t           want;
		logic [SIZE_W-1:0] want_size;
		if (!rst) begin
			if (stall_seen) begin
				assert (r_valid) else begin
					beat_errors++;
					$display("r_valid dropped while a beat was stalled");
				end
				assert (r == stall_beat) else begin
					beat_errors++;
					$display("FAILED r expected %h got %h", stall_beat, r);
				end
			end
			if (r_valid && r_ready) begin
				beats_seen++;
				if (exp_q.size() == 0) begin
					beat_errors++;
					$display("beat with id %h arrived with no burst outstanding", r.id);
				end else begin
					want = exp_q.pop_front();
					assert (r.id == want.id) else begin
						beat_errors++;
						$display("FAILED r.id expected %h got %h", want.id, r.id);
					end
					assert (r.resp == want.resp) else begin
						beat_errors++;
						$display("FAILED r.resp expected %h got %h", want.resp, r.resp);
					end
					assert (r.data == want.data) else begin
						beat_errors++;
						$display("FAILED r.data expected %h got %h", want.data, r.data);
					end
					assert (r.last == want.last) else begin
						beat_errors++;
						$display("FAILED r.last expected %h got %h", want.last, r.last);
					end
				end
			end
			// table fetches read a single 64-byte line
			if (phys_ar_valid && phys_ar_ready && !phys_ar.id[0]) begin
				assert (phys_ar.size == 3'b110) else begin
					seq_errors++;
					$display("FAILED phys_ar.size expected %h got %h", 3'b110, phys_ar.size);
				end
			end
			if (phys_ar_valid && phys_ar_ready && phys_ar.id[0]) begin
				if (size_q.size() == 0) begin
					seq_errors++;
					$display("data read issued with no forwarded burst pending");
				end else begin
					want_size = size_q.pop_front();
					assert (phys_ar.size == want_size) else begin
						seq_errors++;
						$display("FAILED phys_ar.size expected %h got %h",
							want_size, phys_ar.size);
					end
				end
			end
			if (ar_valid && ar_ready) begin
				expect_burst(ar);
			end
		end
		stall_seen = !rst && r_valid && !r_ready;
		stall_beat = r;
	end

	// starts on a falling edge and returns on the one after the handshake
	task automatic send_read(input logic [ID_W-1:0] id, input logic [VPN_W-1:0] vpn,
			input logic [PAGE_OFS_W-1:0] ofs, input logic [LEN_W-1:0] len,
			input logic [SIZE_W-1:0] size);
		ar.id = id;
		ar.addr = {vpn, ofs};
		ar.len = len;
		ar.size = size;
		ar_valid = 1'b1;
		while (!ar_ready) @(negedge clk);
		@(negedge clk);
	endtask

	task automatic send_random(input int n);
		logic [31:0]      vr;
		logic [31:0]      lr;
		logic [VPN_W-1:0] vpn;
		vr = $random(seed);
		lr = $random(seed);
		vpn = VPN_W'(vr[PT_INDEX_W-1:0]);
		// an upper vpn bit lands on the same line and must miss on the tag
		vpn[PT_INDEX_W] = (lr[20:18] == 3'd0);
		send_read(ID_W'(n + 4), vpn, lr[PAGE_OFS_W-1:0], {5'd0, lr[14:12]}, lr[17:15]);
	endtask

	task automatic wait_drain();
		ar_valid = 1'b0;
		while (exp_q.size() != 0) @(negedge clk);
	endtask

	initial begin
		fork
			forever begin
				@(negedge clk);
				r_ready = !stall_en || (($random(seed) & 3) != 0);
			end
		join_none
		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		// idle state after reset
		assert (!r_valid && !phys_ar_valid) else begin
			seq_errors++;
			$display("FAILED r_valid/phys_ar_valid expected 0 got %h/%h", r_valid, phys_ar_valid);
		end
		assert (ar_ready) else begin
			seq_errors++;
			$display("FAILED ar_ready expected 1 got %h", ar_ready);
		end
		// mapped, unmapped, then not readable
		send_read(16'h1, 52'd5, 12'h340, 8'd3, 3'b110);
		send_read(16'h2, 52'd15, 12'h000, 8'd2, 3'b110);
		send_read(16'h3, 52'd11, 12'hffc, 8'd0, 3'b110);
		wait_drain();
		for (int i = 0; i < RAND_REQS; i++) begin
			send_random(i);
		end
		wait_drain();
		stall_en = 1'b1;
		for (int i = RAND_REQS; i < 2 * RAND_REQS; i++) begin
			send_random(i);
		end
		wait_drain();
		stall_en = 1'b0;
		repeat (20) @(negedge clk);
		assert (!r_valid) else begin
			seq_errors++;
			$display("r_valid still high after every burst completed");
		end
		$display("beats checked: %0d, beat errors: %0d, other errors: %0d",
			beats_seen, beat_errors, seq_errors);
		if (beat_errors == 0 && seq_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(NUM_REQS * 200);
		$display("run stopped by watchdog with %0d beats still expected", exp_q.size());
		$display("Test failures found");
		$finish;
	end

endmodule

//--- axi_tlb.f
rtl/axi_tlb_pkg.sv
rtl/sync_fifo.sv
rtl/pte_walker.sv
rtl/phys_read_arbiter.sv
rtl/tlb_ctrl.sv
rtl/axi_tlb_top.sv
bench/phys_mem_model.sv
bench/axi_tlb_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vaxi_tlb_tb: axi_tlb.f $(wildcard rtl/*.sv bench/*.sv)
	verilator --binary --timing --assert -f axi_tlb.f --top-module axi_tlb_tb -o Vaxi_tlb_tb

run: obj_dir/Vaxi_tlb_tb
	./obj_dir/Vaxi_tlb_tb | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f axi_tlb.f --top-module axi_tlb_top

clean:
	rm -rf obj_dir $(LOG)
